/* core_cfg.svh */
`ifndef CORE_CFG_SVH
`define CORE_CFG_SVH

// data path width
`define CORE_XLEN 32

// architectural registers, x0 included
`define CORE_NREGS 32

// first pc after reset
`define CORE_RESET_PC 32'h0000_0000

`endif

/* isa_pkg.sv */
`include "core_cfg.svh"

package isa_pkg;

  typedef logic [`CORE_XLEN-1:0] word_t;
  typedef logic [4:0] reg_idx_t;
  typedef logic [2:0] funct3_t;
  typedef logic [6:0] funct7_t;

  // major opcodes, bits [6:0] of the word
  typedef enum logic [6:0] {
    OP     = 7'b0110011,
    OP_IMM = 7'b0010011,
    LUI    = 7'b0110111,
    AUIPC  = 7'b0010111,
    JAL    = 7'b1101111,
    JALR   = 7'b1100111,
    BRANCH = 7'b1100011
  } opcode_e;

  // funct3 for OP and OP_IMM
  localparam funct3_t F3_ADD_SUB = 3'b000;
  localparam funct3_t F3_SLL     = 3'b001;
  localparam funct3_t F3_SLT     = 3'b010;
  localparam funct3_t F3_SLTU    = 3'b011;
  localparam funct3_t F3_XOR     = 3'b100;
  localparam funct3_t F3_SRL_SRA = 3'b101;
  localparam funct3_t F3_OR      = 3'b110;
  localparam funct3_t F3_AND     = 3'b111;

  // funct3 for BRANCH
  localparam funct3_t F3_BEQ  = 3'b000;
  localparam funct3_t F3_BNE  = 3'b001;
  localparam funct3_t F3_BLT  = 3'b100;
  localparam funct3_t F3_BGE  = 3'b101;
  localparam funct3_t F3_BLTU = 3'b110;
  localparam funct3_t F3_BGEU = 3'b111;

endpackage

/* core_pkg.sv */
`include "core_cfg.svh"

package core_pkg;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND
  } alu_op_e;

  // whole register bank, entry 0 in the low word
  typedef isa_pkg::word_t [`CORE_NREGS-1:0] regs_t;

  // one enable bit per register
  typedef logic [`CORE_NREGS-1:0] wr_vec_t;

  typedef struct packed {
    isa_pkg::word_t    op_a;
    isa_pkg::word_t    op_b;
    alu_op_e           alu_op;
    isa_pkg::reg_idx_t rd;
    logic              wr;
    logic              branch;
    isa_pkg::funct3_t  funct3;
    logic              jump;
    isa_pkg::word_t    tgt_base;
    isa_pkg::word_t    tgt_off;
    isa_pkg::word_t    rs1_val;
    isa_pkg::word_t    rs2_val;
    isa_pkg::word_t    pc;
  } dec_op_t;

  typedef struct packed {
    isa_pkg::word_t    data;
    logic              wr;
    isa_pkg::reg_idx_t rd;
    logic              redirect;
    isa_pkg::word_t    target;
  } exe_res_t;

  typedef struct packed {
    logic              valid;
    isa_pkg::reg_idx_t rd;
    logic              wr;
    isa_pkg::word_t    data;
    isa_pkg::word_t    next_pc;
  } retire_t;

endpackage

/* riscv_regfile.sv */
`timescale 1ns/100ps

`include "core_cfg.svh"

module riscv_regfile (
  input  logic              clk,
  input  logic              rst,

  input  logic              pc_wr,
  input  isa_pkg::word_t    pc_in,

  input  core_pkg::wr_vec_t x_wr,
  input  isa_pkg::word_t    x_in,

  output isa_pkg::word_t    pc,
  output core_pkg::regs_t   regs
);

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      pc   <= `CORE_RESET_PC;
      regs <= '0;
    end
    else
    begin
      if (pc_wr)
      begin
        pc <= pc_in;
      end

      for (int i = 1; i < `CORE_NREGS; i++)
      begin
        if (x_wr[i])
        begin
          regs[i] <= x_in;
        end
      end

      // x0 reads as zero whatever the enable says
      regs[0] <= '0;
    end
  end

endmodule

/* riscv_decode.sv */
`timescale 1ns/100ps

module riscv_decode (
  input  isa_pkg::word_t    instr,
  input  isa_pkg::word_t    pc,
  input  core_pkg::regs_t   regs,
  output core_pkg::dec_op_t dec
);

  isa_pkg::opcode_e  opcode;
  isa_pkg::reg_idx_t rs1;
  isa_pkg::reg_idx_t rs2;
  isa_pkg::reg_idx_t rd;
  isa_pkg::funct3_t  funct3;
  isa_pkg::funct7_t  funct7;
  isa_pkg::word_t    rs1_val;
  isa_pkg::word_t    rs2_val;
  isa_pkg::word_t    imm_i;
  isa_pkg::word_t    imm_u;
  isa_pkg::word_t    imm_b;
  isa_pkg::word_t    imm_j;
  core_pkg::alu_op_e alu_op;
  logic              sub_sel;

  assign opcode = isa_pkg::opcode_e'(instr[6:0]);
  assign rd     = instr[11:7];
  assign funct3 = instr[14:12];
  assign rs1    = instr[19:15];
  assign rs2    = instr[24:20];
  assign funct7 = instr[31:25];

  assign rs1_val = regs[rs1];
  assign rs2_val = regs[rs2];

  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_u = {instr[31:12], 12'b0};
  assign imm_b = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_j = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

  // addi has no sub form, imm[10] is just part of the constant
  assign sub_sel = funct7[5] && (opcode == isa_pkg::OP);

  always_comb
  begin
    case (funct3)
      isa_pkg::F3_ADD_SUB: alu_op = sub_sel ? core_pkg::ALU_SUB : core_pkg::ALU_ADD;
      isa_pkg::F3_SLL:     alu_op = core_pkg::ALU_SLL;
      isa_pkg::F3_SLT:     alu_op = core_pkg::ALU_SLT;
      isa_pkg::F3_SLTU:    alu_op = core_pkg::ALU_SLTU;
      isa_pkg::F3_XOR:     alu_op = core_pkg::ALU_XOR;
      isa_pkg::F3_SRL_SRA: alu_op = funct7[5] ? core_pkg::ALU_SRA : core_pkg::ALU_SRL;
      isa_pkg::F3_OR:      alu_op = core_pkg::ALU_OR;
      default:             alu_op = core_pkg::ALU_AND;
    endcase
  end

  always_comb
  begin
    dec         = '0;
    dec.pc      = pc;
    dec.rd      = rd;
    dec.funct3  = funct3;
    dec.rs1_val = rs1_val;
    dec.rs2_val = rs2_val;
    dec.alu_op  = core_pkg::ALU_ADD;

    case (opcode)
      isa_pkg::OP:
      begin
        dec.op_a   = rs1_val;
        dec.op_b   = rs2_val;
        dec.alu_op = alu_op;
        dec.wr     = 1'b1;
      end
      isa_pkg::OP_IMM:
      begin
        dec.op_a   = rs1_val;
        dec.op_b   = imm_i;
        dec.alu_op = alu_op;
        dec.wr     = 1'b1;
      end
      isa_pkg::LUI:
      begin
        dec.op_b = imm_u;
        dec.wr   = 1'b1;
      end
      isa_pkg::AUIPC:
      begin
        dec.op_a = pc;
        dec.op_b = imm_u;
        dec.wr   = 1'b1;
      end
      isa_pkg::JAL:
      begin
        // link value pc + 4 through the adder
        dec.op_a     = pc;
        dec.op_b     = isa_pkg::word_t'(4);
        dec.wr       = 1'b1;
        dec.jump     = 1'b1;
        dec.tgt_base = pc;
        dec.tgt_off  = imm_j;
      end
      isa_pkg::JALR:
      begin
        dec.op_a     = pc;
        dec.op_b     = isa_pkg::word_t'(4);
        dec.wr       = 1'b1;
        dec.jump     = 1'b1;
        dec.tgt_base = rs1_val;
        dec.tgt_off  = imm_i;
      end
      isa_pkg::BRANCH:
      begin
        dec.branch   = 1'b1;
        dec.tgt_base = pc;
        dec.tgt_off  = imm_b;
      end
      default:
      begin
        // unsupported, retires as a nop
        dec.rd = '0;
      end
    endcase
  end

endmodule

/* riscv_execute.sv */
`timescale 1ns/100ps

module riscv_execute (
  input  core_pkg::dec_op_t  dec,
  output core_pkg::exe_res_t res
);

  isa_pkg::word_t alu_out;
  isa_pkg::word_t target;
  logic [4:0]     shamt;
  logic           taken;

  assign shamt = dec.op_b[4:0];

  always_comb
  begin
    case (dec.alu_op)
      core_pkg::ALU_ADD:  alu_out = dec.op_a + dec.op_b;
      core_pkg::ALU_SUB:  alu_out = dec.op_a - dec.op_b;
      core_pkg::ALU_SLL:  alu_out = dec.op_a << shamt;
      core_pkg::ALU_SLT:  alu_out = isa_pkg::word_t'($signed(dec.op_a) < $signed(dec.op_b));
      core_pkg::ALU_SLTU: alu_out = isa_pkg::word_t'(dec.op_a < dec.op_b);
      core_pkg::ALU_XOR:  alu_out = dec.op_a ^ dec.op_b;
      core_pkg::ALU_SRL:  alu_out = dec.op_a >> shamt;
      core_pkg::ALU_SRA:  alu_out = $signed(dec.op_a) >>> shamt;
      core_pkg::ALU_OR:   alu_out = dec.op_a | dec.op_b;
      default:            alu_out = dec.op_a & dec.op_b;
    endcase
  end

  // branch condition on the raw register values
  always_comb
  begin
    case (dec.funct3)
      isa_pkg::F3_BEQ:  taken = (dec.rs1_val == dec.rs2_val);
      isa_pkg::F3_BNE:  taken = (dec.rs1_val != dec.rs2_val);
      isa_pkg::F3_BLT:  taken = ($signed(dec.rs1_val) < $signed(dec.rs2_val));
      isa_pkg::F3_BGE:  taken = ($signed(dec.rs1_val) >= $signed(dec.rs2_val));
      isa_pkg::F3_BLTU: taken = (dec.rs1_val < dec.rs2_val);
      isa_pkg::F3_BGEU: taken = (dec.rs1_val >= dec.rs2_val);
      default:          taken = 1'b0;
    endcase
  end

  assign target = dec.tgt_base + dec.tgt_off;

  always_comb
  begin
    res          = '0;
    res.data     = alu_out;
    res.wr       = dec.wr;
    res.rd       = dec.rd;
    res.redirect = dec.jump | (dec.branch & taken);
    // jalr needs bit 0 cleared, other targets are even anyway
    res.target   = target & ~isa_pkg::word_t'(1);
  end

endmodule

/* riscv_result.sv */
`timescale 1ns/100ps

module riscv_result (
  input  logic               clk,
  input  logic               rst,
  input  logic               instr_valid,
  input  isa_pkg::word_t     pc,
  input  core_pkg::exe_res_t res,

  output logic               pc_wr,
  output isa_pkg::word_t     pc_in,
  output core_pkg::wr_vec_t  x_wr,
  output isa_pkg::word_t     x_in,
  output core_pkg::retire_t  retire
);

  logic wr_en;

  // never write x0
  assign wr_en = res.wr && (res.rd != '0);

  assign pc_wr = instr_valid;
  assign pc_in = res.redirect ? res.target : pc + isa_pkg::word_t'(4);
  assign x_in  = res.data;

  always_comb
  begin
    x_wr         = '0;
    x_wr[res.rd] = instr_valid & wr_en;
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      retire <= '0;
    end
    else
    begin
      retire.valid <= instr_valid;
      if (instr_valid)
      begin
        retire.rd      <= res.rd;
        retire.wr      <= wr_en;
        retire.data    <= res.data;
        retire.next_pc <= pc_in;
      end
    end
  end

endmodule

/* riscv_core.sv */
`timescale 1ns/100ps

module riscv_core (
  input  logic              clk,
  input  logic              rst,
  input  logic              instr_valid,
  input  isa_pkg::word_t    instr,
  output isa_pkg::word_t    pc,
  output core_pkg::retire_t retire
);

  core_pkg::regs_t    regs;
  core_pkg::dec_op_t  dec;
  core_pkg::exe_res_t res;
  core_pkg::wr_vec_t  x_wr;
  isa_pkg::word_t     x_in;
  isa_pkg::word_t     pc_in;
  logic               pc_wr;

  riscv_regfile u_regfile (
    .clk   (clk),
    .rst   (rst),
    .pc_wr (pc_wr),
    .pc_in (pc_in),
    .x_wr  (x_wr),
    .x_in  (x_in),
    .pc    (pc),
    .regs  (regs)
  );

  riscv_decode u_decode (
    .instr (instr),
    .pc    (pc),
    .regs  (regs),
    .dec   (dec)
  );

  riscv_execute u_execute (
    .dec (dec),
    .res (res)
  );

  riscv_result u_result (
    .clk         (clk),
    .rst         (rst),
    .instr_valid (instr_valid),
    .pc          (pc),
    .res         (res),
    .pc_wr       (pc_wr),
    .pc_in       (pc_in),
    .x_wr        (x_wr),
    .x_in        (x_in),
    .retire      (retire)
  );

endmodule

/* tb_riscv_core.sv */
`timescale 1ns/100ps

`include "core_cfg.svh"

module tb_riscv_core;

  localparam int CLK_PERIOD   = 40;
  localparam int RESET_CYCLES = 16;
  localparam int NUM_INSTR    = 2000;
  // about 2700 cycles expected at three strobes in four
  localparam int MAX_CYCLES   = 3000 + RESET_CYCLES;

  localparam logic [31:0] LFSR_SEED = 32'h3e23ad4d;
  localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;
  localparam logic [6:0]  ILLEGAL_OPCODE = 7'b0000011;

  logic              clk;
  logic              rst;
  logic              instr_valid;
  isa_pkg::word_t    instr;
  isa_pkg::word_t    pc;
  core_pkg::retire_t retire;

  logic [31:0] lfsr;
  int          cycles;
  int          sent;

  // reference model state
  isa_pkg::word_t    model_x [`CORE_NREGS];
  isa_pkg::word_t    model_pc;
  logic              exp_valid;
  logic              exp_wr;
  isa_pkg::reg_idx_t exp_rd;
  isa_pkg::word_t    exp_data;

  riscv_core u_dut (
    .clk         (clk),
    .rst         (rst),
    .instr_valid (instr_valid),
    .instr       (instr),
    .pc          (pc),
    .retire      (retire)
  );

  initial
  begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    if (s[0])
      return (s >> 1) ^ LFSR_TAPS;
    return s >> 1;
  endfunction

  // one lfsr step per bit
  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      v    = {v[30:0], lfsr[0]};
      lfsr = lfsr_next(lfsr);
    end
  endtask

  task automatic value_error(input string name, input isa_pkg::word_t exp,
                             input isa_pkg::word_t act);
    $display("[FAIL] %s expected %08h actual %08h", name, exp, act);
    $display("TEST FAILED");
    $fatal(1, "stopping at first mismatch");
  endtask

  function automatic isa_pkg::word_t alu_calc(input logic [2:0] f3, input logic alt,
                                              input isa_pkg::word_t a,
                                              input isa_pkg::word_t b);
    case (f3)
      3'b000: return alt ? a - b : a + b;
      3'b001: return a << b[4:0];
      3'b010: return {31'b0, ($signed(a) < $signed(b))};
      3'b011: return {31'b0, (a < b)};
      3'b100: return a ^ b;
      3'b101:
      begin
        // kept apart so the arithmetic shift stays signed
        if (alt)
          return $signed(a) >>> b[4:0];
        return a >> b[4:0];
      end
      3'b110: return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic logic branch_taken(input logic [2:0] f3, input isa_pkg::word_t a,
                                        input isa_pkg::word_t b);
    case (f3)
      3'b000: return a == b;
      3'b001: return a != b;
      3'b100: return $signed(a) < $signed(b);
      3'b101: return $signed(a) >= $signed(b);
      3'b110: return a < b;
      3'b111: return a >= b;
      default: return 1'b0;
    endcase
  endfunction

  task automatic make_instr(output isa_pkg::word_t w);
    logic [31:0] r;
    logic [6:0]  opc;
    logic [2:0]  f3;
    logic [6:0]  f7;
    take_bits(3, r);
    case (r[2:0])
      3'd0: opc = isa_pkg::OP;
      3'd1: opc = isa_pkg::OP_IMM;
      3'd2: opc = isa_pkg::LUI;
      3'd3: opc = isa_pkg::AUIPC;
      3'd4: opc = isa_pkg::JAL;
      3'd5: opc = isa_pkg::JALR;
      3'd6: opc = isa_pkg::BRANCH;
      default: opc = ILLEGAL_OPCODE;
    endcase
    take_bits(25, r);
    w  = {r[24:0], opc};
    f3 = w[14:12];
    take_bits(1, r);
    f7 = {1'b0, r[0], 5'b0};
    case (opc)
      isa_pkg::OP: w[31:25] = (f3 == 3'b000 || f3 == 3'b101) ? f7 : 7'b0;
      isa_pkg::OP_IMM:
      begin
        if (f3 == 3'b001)
          w[31:25] = 7'b0;
        else if (f3 == 3'b101)
          w[31:25] = f7;
      end
      isa_pkg::JALR: w[14:12] = 3'b000;
      // 010 and 011 are not branches, move them to bltu and bgeu
      isa_pkg::BRANCH: w[14] = w[14] | (f3[2:1] == 2'b01);
      default: ;
    endcase
  endtask

  task automatic model_step(input isa_pkg::word_t w);
    logic [6:0]        opc;
    logic [2:0]        f3;
    isa_pkg::reg_idx_t rd;
    isa_pkg::word_t    a;
    isa_pkg::word_t    b;
    isa_pkg::word_t    imm_i;
    isa_pkg::word_t    imm_u;
    isa_pkg::word_t    imm_b;
    isa_pkg::word_t    imm_j;
    isa_pkg::word_t    val;
    isa_pkg::word_t    next_pc;
    logic              wr;
    opc   = w[6:0];
    f3    = w[14:12];
    rd    = w[11:7];
    a     = model_x[w[19:15]];
    b     = model_x[w[24:20]];
    imm_i = {{20{w[31]}}, w[31:20]};
    imm_u = {w[31:12], 12'b0};
    imm_b = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
    imm_j = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
    val     = '0;
    wr      = 1'b1;
    next_pc = model_pc + 32'd4;
    case (opc)
      isa_pkg::OP:     val = alu_calc(f3, w[30], a, b);
      isa_pkg::OP_IMM: val = alu_calc(f3, w[30] && f3 == 3'b101, a, imm_i);
      isa_pkg::LUI:    val = imm_u;
      isa_pkg::AUIPC:  val = model_pc + imm_u;
      isa_pkg::JAL:
      begin
        val     = model_pc + 32'd4;
        next_pc = model_pc + imm_j;
      end
      isa_pkg::JALR:
      begin
        val     = model_pc + 32'd4;
        next_pc = (a + imm_i) & 32'hffff_fffe;
      end
      isa_pkg::BRANCH:
      begin
        wr = 1'b0;
        if (branch_taken(f3, a, b))
          next_pc = model_pc + imm_b;
      end
      default: wr = 1'b0;
    endcase
    exp_valid = 1'b1;
    exp_wr    = wr && (rd != 5'd0);
    exp_rd    = rd;
    exp_data  = val;
    if (exp_wr)
      model_x[rd] = val;
    model_pc = next_pc;
  endtask

  task automatic check_reset;
    assert (pc == `CORE_RESET_PC) else value_error("pc", `CORE_RESET_PC, pc);
    assert (retire.valid == 1'b0) else value_error("retire.valid", 32'd0, {31'b0, retire.valid});
    assert (retire.wr == 1'b0) else value_error("retire.wr", 32'd0, {31'b0, retire.wr});
    assert (retire.rd == 5'd0) else value_error("retire.rd", 32'd0, {27'b0, retire.rd});
    assert (retire.data == '0) else value_error("retire.data", 32'd0, retire.data);
    assert (retire.next_pc == '0) else value_error("retire.next_pc", 32'd0, retire.next_pc);
  endtask

  task automatic check_state;
    assert (retire.valid == exp_valid)
      else value_error("retire.valid", {31'b0, exp_valid}, {31'b0, retire.valid});
    assert (pc == model_pc) else value_error("pc", model_pc, pc);
    if (exp_valid)
    begin
      assert (retire.next_pc == model_pc)
        else value_error("retire.next_pc", model_pc, retire.next_pc);
      assert (retire.wr == exp_wr)
        else value_error("retire.wr", {31'b0, exp_wr}, {31'b0, retire.wr});
      if (exp_wr)
      begin
        assert (retire.rd == exp_rd)
          else value_error("retire.rd", {27'b0, exp_rd}, {27'b0, retire.rd});
        assert (retire.data == exp_data)
          else value_error("retire.data", exp_data, retire.data);
      end
    end
  endtask

  task automatic drive_cycle;
    logic [31:0]    r;
    isa_pkg::word_t w;
    take_bits(2, r);
    if (r[1:0] != 2'b00)
    begin
      make_instr(w);
      instr       = w;
      instr_valid = 1'b1;
      model_step(w);
      sent++;
    end
    else
    begin
      // old word stays on instr and must be ignored
      instr_valid = 1'b0;
      exp_valid   = 1'b0;
    end
  endtask

  initial
  begin
    rst         = 1'b1;
    instr_valid = 1'b0;
    instr       = '0;
    lfsr        = LFSR_SEED;
    sent        = 0;
    model_pc    = `CORE_RESET_PC;
    exp_valid   = 1'b0;
    exp_wr      = 1'b0;
    exp_rd      = '0;
    exp_data    = '0;
    for (int i = 0; i < `CORE_NREGS; i++)
      model_x[i] = '0;

    repeat (RESET_CYCLES) @(posedge clk);
    #2;
    rst = 1'b0;
    check_reset;

    while (sent < NUM_INSTR)
    begin
      @(posedge clk);
      #1;
      check_state;
      #1;
      drive_cycle;
    end
    @(posedge clk);
    #1;
    check_state;
    $display("TEST OK");
    $finish;
  end

  initial
  begin
    cycles = 0;
    forever
    begin
      @(posedge clk);
      cycles++;
      if (cycles > MAX_CYCLES)
      begin
        $display("timeout: %0d of %0d instructions sent after %0d cycles",
                 sent, NUM_INSTR, cycles);
        $display("TEST FAILED");
        $fatal(1, "cycle limit reached");
      end
    end
  end

endmodule

/* flist.f */
+incdir+.
isa_pkg.sv
core_pkg.sv
riscv_regfile.sv
riscv_decode.sv
riscv_execute.sv
riscv_result.sv
riscv_core.sv
tb_riscv_core.sv

/* run.sh */
#!/bin/bash
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --timescale 1ns/100ps -f flist.f \
  --top-module tb_riscv_core -Mdir obj_dir &&
./obj_dir/Vtb_riscv_core ||
{ echo "simulation build or run failed"; exit 1; }
